//--- build.f
lsuConfigPkg.sv
lsuOpPkg.sv
lsuAddressStage.sv
lsuStoreFormat.sv
dtimArray.sv
lsuLoadFormat.sv
lsuTop.sv
lsuTb.sv

//--- dtimArray.sv
// Single port RAM without reset; the read port runs every enabled cycle that does not write
`timescale 1ns/100ps

module dtimArray
  import lsuConfigPkg::*, lsuOpPkg::*;
#(
  parameter int DtimWords = 512                  // Depth in words, power of two
) (
  input  logic                         clk,
  input  logic                         enable,        // Low freezes the array and read port
  input  memRwT                        dtimRw,        // Gated direction from the address stage
  input  logic [$clog2(DtimWords)-1:0] dtimAdr,       // Word index
  input  xlenWordT                     dtimWriteData, // Store data already in lane order
  input  byteMaskT                     byteMaskM,     // Lanes to write
  output xlenWordT                     dtimReadWord   // Word read one cycle after its index
);

  xlenWordT mem [DtimWords];                     // Storage array

  //////////////////////////////////////////////////
  // Array port
  //////////////////////////////////////////////////

  // The load's index arrives from E before its request reaches M
  // so the read is taken on every enabled non-write cycle
  always_ff @(posedge clk) begin
    if (enable) begin
      if (dtimRw == MemWrite) begin
        for (int k = 0; k < XlenBytes; k++) begin
          if (byteMaskM[k]) begin
            mem[dtimAdr][8*k +: 8] <= dtimWriteData[8*k +: 8]; // Only masked lanes change
          end
        end
      end else begin
        dtimReadWord <= mem[dtimAdr];            // Ready for the load in M
      end
    end
  end

  // A write needs a settled index inside the array
  adrRangeA: assert property (@(posedge clk)
    enable && dtimRw == MemWrite |-> !$isunknown(dtimAdr) && dtimAdr < DtimWords)
    else $error("DTIM write index unknown or out of range");

endmodule

//--- lsuAddressStage.sv
// Untranslated DTIM addresses only; a load in E must not overlap a store in M
`timescale 1ns/100ps

module lsuAddressStage
  import lsuConfigPkg::*, lsuOpPkg::*;
#(
  parameter int DtimWords = 512                  // DTIM depth in words, power of two
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         StallM,    // Hold the M address
  input  logic                         FlushM,    // Squash the M address
  input  logic                         FlushW,    // Drop the access now in M
  input  xlenWordT                     IEUAdrE,   // Address computed in E
  input  memReqT                       memReqM,   // Request of the instruction in M
  output xlenWordT                     IEUAdrM,   // Address of the instruction in M
  output logic [$clog2(DtimWords)-1:0] dtimAdr,   // Word index into the DTIM
  output memRwT                        dtimRw,    // Gated direction for the DTIM
  output logic                         LoadMisalignedFaultM,
  output logic                         StoreAmoMisalignedFaultM
);

  localparam int IndexBits = $clog2(DtimWords);  // Word index width

  logic [ByteOffsetBits-1:0] byteOffset;         // Byte position within the word
  logic                      misaligned;         // Address not a multiple of the size
  xlenWordT                  dtimSrcAdr;         // E or M address feeding the index

  //////////////////////////////////////////////////
  // E to M address register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || FlushM) begin
      IEUAdrM <= '0;                             // Flush wins over stall
    end else if (!StallM) begin
      IEUAdrM <= IEUAdrE;
    end
  end

  //////////////////////////////////////////////////
  // Alignment check
  //////////////////////////////////////////////////

  assign byteOffset = IEUAdrM[ByteOffsetBits-1:0];

  always_comb begin
    case (memReqM.size)
      SizeByte: misaligned = 1'b0;               // Any byte address is fine
      SizeHalf: misaligned = byteOffset[0];
      SizeWord: misaligned = |byteOffset[1:0];
      default:  misaligned = |byteOffset;        // Doubleword needs all three clear
    endcase
  end

  assign LoadMisalignedFaultM     = misaligned && (memReqM.rw == MemRead);
  assign StoreAmoMisalignedFaultM = misaligned && (memReqM.rw == MemWrite);

  //////////////////////////////////////////////////
  // DTIM address and direction
  //////////////////////////////////////////////////

  // A store writes in its own M cycle with the M address
  // Otherwise the E address is presented so a load's word is ready once it reaches M
  assign dtimSrcAdr = (memReqM.rw == MemWrite) ? IEUAdrM : IEUAdrE;
  assign dtimAdr    = dtimSrcAdr[ByteOffsetBits +: IndexBits];

  // Faulting or flushed accesses never touch the array
  assign dtimRw = (FlushW || LoadMisalignedFaultM || StoreAmoMisalignedFaultM) ?
                  MemNone : memReqM.rw;

  // The M address only moves when the pipeline lets it
  adrHoldA: assert property (@(posedge clk) disable iff (reset)
    $changed(IEUAdrM) |-> $past(!StallM || FlushM || reset))
    else $error("IEUAdrM changed while StallM held it");

endmodule

//--- lsuConfigPkg.sv
// Datapath widths fixed at a 64-bit XLEN; the swap helper assumes whole-byte words
package lsuConfigPkg;

  //////////////////////////////////////////////////
  // Word geometry
  //////////////////////////////////////////////////

  parameter int Xlen           = 64;              // Integer register and DTIM word width
  parameter int XlenBytes      = Xlen / 8;        // Bytes per word
  parameter int ByteOffsetBits = $clog2(XlenBytes); // Address bits below the word index

  typedef logic [Xlen-1:0]      xlenWordT;       // One data word
  typedef logic [XlenBytes-1:0] byteMaskT;       // One write enable per byte lane

  //////////////////////////////////////////////////
  // Endian helper
  //////////////////////////////////////////////////

  // Reverse byte order within a word
  // Shared by the store path and the load path so both agree on lane order
  function automatic xlenWordT endianSwap(input xlenWordT word);
    xlenWordT swapped;
    for (int k = 0; k < XlenBytes; k++) begin
      swapped[8*k +: 8] = word[8*(XlenBytes-1-k) +: 8]; // Lane k takes lane XlenBytes-1-k
    end
    return swapped;
  endfunction

endpackage

//--- lsuLoadFormat.sv
// Field select assumes an aligned load; doubleword loads ignore the unsigned flag
`timescale 1ns/100ps

module lsuLoadFormat
  import lsuConfigPkg::*, lsuOpPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     StallW,                       // Hold the W register
  input  xlenWordT dtimReadWord,                 // Raw word from the DTIM
  input  memReqT   memReqM,                      // Request of the load in M
  input  xlenWordT IEUAdrM,                      // Only the byte offset is used
  output xlenWordT ReadDataW                     // Formatted load result in W
);

  xlenWordT                  loadWord;           // Word in little-endian lane order
  logic [ByteOffsetBits-1:0] laneOffset;         // Offset after endian correction
  logic [7:0]                byteField;          // Addressed byte
  logic [15:0]               halfField;          // Addressed halfword
  logic [31:0]               wordField;          // Addressed word
  logic                      signedLoad;         // Extend with the top bit of the field
  xlenWordT                  readDataM;          // Result before the W register

  //////////////////////////////////////////////////
  // Big-endian swap
  //////////////////////////////////////////////////

  assign loadWord = memReqM.bigEndian ? endianSwap(dtimReadWord) : dtimReadWord;

  // After the swap byte k of memory sits in lane XlenBytes-1-k
  // Inverting the offset finds the same field from the other end
  assign laneOffset = IEUAdrM[ByteOffsetBits-1:0] ^ {ByteOffsetBits{memReqM.bigEndian}};

  //////////////////////////////////////////////////
  // Subword select and extension
  //////////////////////////////////////////////////

  assign byteField = loadWord[{laneOffset, 3'b000} +: 8];
  assign halfField = loadWord[{laneOffset[2:1], 4'b0000} +: 16]; // Low offset bit dropped
  assign wordField = loadWord[{laneOffset[2], 5'b00000} +: 32];
  assign signedLoad = !memReqM.unsignedLoad;

  always_comb begin
    case (memReqM.size)
      SizeByte: readDataM = {{(Xlen-8){signedLoad & byteField[7]}}, byteField};
      SizeHalf: readDataM = {{(Xlen-16){signedLoad & halfField[15]}}, halfField};
      SizeWord: readDataM = {{(Xlen-32){signedLoad & wordField[31]}}, wordField};
      default:  readDataM = loadWord;            // Doubleword passes whole
    endcase
  end

  //////////////////////////////////////////////////
  // M to W register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      ReadDataW <= '0;
    end else if (!StallW) begin
      ReadDataW <= readDataM;                    // StallW keeps the last result
    end
  end

  // A completed load brings back defined data from the array
  loadKnownA: assert property (@(posedge clk) disable iff (reset)
    !StallW && memReqM.rw == MemRead |=> !$isunknown(ReadDataW))
    else $error("ReadDataW holds X after a load");

endmodule

//--- lsuOpPkg.sv
// Request encodings for integer loads and stores only; atomics and FP accesses are not encoded
package lsuOpPkg;

  //////////////////////////////////////////////////
  // Memory direction
  //////////////////////////////////////////////////

  // Same bit meaning as the core's MemRW pair
  // Bit 1 requests a read, bit 0 requests a write
  typedef enum logic [1:0] {
    MemNone  = 2'b00,                            // Idle slot
    MemWrite = 2'b01,                            // Store
    MemRead  = 2'b10                             // Load
  } memRwT;

  //////////////////////////////////////////////////
  // Access size
  //////////////////////////////////////////////////

  // Low two bits of Funct3
  typedef enum logic [1:0] {
    SizeByte   = 2'd0,                           // lb lbu sb
    SizeHalf   = 2'd1,                           // lh lhu sh
    SizeWord   = 2'd2,                           // lw lwu sw
    SizeDouble = 2'd3                            // ld sd
  } accessSizeT;

  //////////////////////////////////////////////////
  // M-stage request
  //////////////////////////////////////////////////

  // Everything the LSU needs about the instruction in M
  // Six bits wide, rw in the top two
  typedef struct packed {
    memRwT      rw;                              // Direction of the access
    accessSizeT size;                            // Bytes moved, as a power of two
    logic       unsignedLoad;                    // Funct3 bit 2, zero extend on load
    logic       bigEndian;                       // Memory is viewed big endian
  } memReqT;

endpackage

//--- lsuStimulus.txt
# test rw(0 none 1 write 2 read) size unsigned bigEndian addr wdata expRead faults(load store)
# ctrl: 0 plain, 1 FlushW on the store in M, 2 StallW hold after the previous load
1 1 3 0 0 100 0123456789abcdef 0 00 0
1 1 3 0 0 108 fedcba9876543210 0 00 0
1 0 0 0 0 0 0 0 00 0
1 2 3 0 0 100 0 0123456789abcdef 00 0
1 2 3 0 0 108 0 fedcba9876543210 00 0
2 1 3 0 0 110 1111111111111111 0 00 0
2 1 0 0 0 111 ffffffffffffffaa 0 00 0
2 1 1 0 0 114 ffffffffffffbbcc 0 00 0
2 1 0 0 0 117 0000000000000055 0 00 0
2 1 3 0 0 118 0 0 00 0
2 1 2 0 0 11c 12345678deadbeef 0 00 0
2 0 0 0 0 0 0 0 00 0
2 2 3 0 0 110 0 5511bbcc1111aa11 00 0
2 2 3 0 0 118 0 deadbeef00000000 00 0
3 1 3 0 0 120 89abcdeffedc8281 0 00 0
3 0 0 0 0 0 0 0 00 0
3 2 0 0 0 120 0 ffffffffffffff81 00 0
3 2 0 1 0 120 0 0000000000000081 00 0
3 2 1 0 0 122 0 fffffffffffffedc 00 0
3 2 1 1 0 122 0 000000000000fedc 00 0
3 2 2 0 0 124 0 ffffffff89abcdef 00 0
3 2 2 1 0 124 0 0000000089abcdef 00 0
3 2 1 0 0 120 0 ffffffffffff8281 00 0
4 1 3 0 1 128 0011223344556677 0 00 0
4 0 0 0 0 0 0 0 00 0
4 2 3 0 1 128 0 0011223344556677 00 0
4 2 3 0 0 128 0 7766554433221100 00 0
4 2 1 1 1 100 0 000000000000efcd 00 0
4 2 1 0 1 102 0 ffffffffffffab89 00 0
4 1 0 0 1 12b 000000000000005a 0 00 0
4 1 1 0 1 12c 000000000000a1b2 0 00 0
4 0 0 0 0 0 0 0 00 0
4 2 2 0 1 128 0 000000000011225a 00 0
4 2 3 0 0 128 0 7766b2a15a221100 00 0
4 2 2 0 1 12c 0 ffffffffa1b26677 00 0
5 2 1 0 0 101 0 0 10 0
5 2 2 0 0 122 0 0 10 0
5 2 3 0 0 124 0 0 10 0
5 1 1 0 0 109 ffffffffffffffff 0 01 0
5 1 2 0 0 10a ffffffffffffffff 0 01 0
5 1 3 0 0 10c ffffffffffffffff 0 01 0
5 0 0 0 0 0 0 0 00 0
5 2 3 0 0 108 0 fedcba9876543210 00 0
6 1 3 0 0 130 aaaa5555aaaa5555 0 00 0
6 1 3 0 0 130 ffffffffffffffff 0 00 1
6 0 0 0 0 0 0 0 00 0
6 2 3 0 0 130 0 aaaa5555aaaa5555 00 0
6 2 3 0 0 100 0 0123456789abcdef 00 0
6 0 0 0 0 0 0 0 00 2
6 0 0 0 0 0 0 0 00 0
6 2 3 0 0 108 0 fedcba9876543210 00 0

//--- lsuStoreFormat.sv
// Mask assumes an aligned access; misaligned stores are blocked in the address stage
`timescale 1ns/100ps

module lsuStoreFormat
  import lsuConfigPkg::*, lsuOpPkg::*;
(
  input  memReqT   memReqM,                      // Request of the store in M
  input  xlenWordT IEUAdrM,                      // Byte address of the store
  input  xlenWordT WriteDataM,                   // Register data with the value in the low bits
  output xlenWordT dtimWriteData,                // Lane-replicated, endian-corrected data
  output byteMaskT byteMaskM                     // Byte lanes to update
);

  logic [ByteOffsetBits-1:0] byteOffset;         // Lane of the first byte written
  xlenWordT                  replicated;         // Store value copied into every lane slot
  byteMaskT                  sizeMask;           // Mask for the size at offset zero

  assign byteOffset = IEUAdrM[ByteOffsetBits-1:0];

  //////////////////////////////////////////////////
  // Subword replication
  //////////////////////////////////////////////////

  // Copying the value into every slot means any aligned offset finds it in place
  always_comb begin
    case (memReqM.size)
      SizeByte: replicated = {(Xlen/8){WriteDataM[7:0]}};
      SizeHalf: replicated = {(Xlen/16){WriteDataM[15:0]}};
      SizeWord: replicated = {(Xlen/32){WriteDataM[31:0]}};
      default:  replicated = WriteDataM;         // Full doubleword
    endcase
  end

  //////////////////////////////////////////////////
  // Byte mask
  //////////////////////////////////////////////////

  always_comb begin
    case (memReqM.size)
      SizeByte: sizeMask = byteMaskT'(8'h01);
      SizeHalf: sizeMask = byteMaskT'(8'h03);
      SizeWord: sizeMask = byteMaskT'(8'h0f);
      default:  sizeMask = '1;                   // Every lane
    endcase
  end

  assign byteMaskM = sizeMask << byteOffset;     // Slide to the addressed lanes

  //////////////////////////////////////////////////
  // Big-endian swap
  //////////////////////////////////////////////////

  // Swapping a replicated pattern keeps each copy on an aligned slot
  // so the mask above stays valid in both byte orders
  assign dtimWriteData = memReqM.bigEndian ? endianSwap(replicated) : replicated;

  // A store must present a defined and nonzero byte mask
  maskValidA: assert final ($isunknown(memReqM.rw) || memReqM.rw != MemWrite ||
                            (!$isunknown(byteMaskM) && byteMaskM != '0))
    else $error("Store byte mask unknown or empty");

endmodule

//--- lsuTb.sv
// Needs lsuStimulus.txt in the run directory; a load must not sit in E while a store is in M
`timescale 1ns/100ps

module lsuTb
  import lsuConfigPkg::*, lsuOpPkg::*;
;

  typedef struct packed {
    logic load;                                  // Load misaligned
    logic store;                                 // Store misaligned
  } faultPairT;

  typedef struct packed {
    int        test;                             // Test number from the file
    memReqT    req;
    xlenWordT  adr;
    xlenWordT  wdata;
    xlenWordT  expRead;                          // File value checked against the model
    faultPairT expFault;
    logic [1:0] ctrl;                            // 1 raises FlushW, 2 holds StallW
  } opT;

  localparam int    HoldCycles = 4;              // Extra StallW cycles
  localparam int    EdgeTries  = 4;              // Clock changes allowed per edge wait
  localparam string StimFile   = "lsuStimulus.txt";

  logic clk, reset, StallM, FlushM, StallW, FlushW;
  xlenWordT IEUAdrE, WriteDataM, IEUAdrM, ReadDataW;
  memReqT memReqM;
  logic LoadMisalignedFaultM, StoreAmoMisalignedFaultM;

  opT         ops[$];                            // Whole stimulus, in order
  logic [7:0] modelMem [longint];                // Byte model of the DTIM
  xlenWordT   modelRead [int];                   // Expected W data per op
  bit         readDue [int];                     // Op is an aligned load
  int         testChecks [int];
  int         testErrs [int];
  int         checks, errors;
  bit         timedOut, fileError;
  string      timeoutWhat;

  lsuTop dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                      // 40 ns period
  end

  initial begin
    #200us;                                      // Global limit that also covers a dead clock
    $display("Simulation ran past its time limit");
    $display("TESTBENCH FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic faultPairT modelFault(input opT op);
    faultPairT f;
    bit mis;
    mis = (op.adr % (64'd1 << op.req.size)) != 0; // Offset not a multiple of the size
    f.load  = mis && op.req.rw == MemRead;
    f.store = mis && op.req.rw == MemWrite;
    return f;
  endfunction

  // Big endian puts the byte at the lowest address in the top of the value
  function automatic xlenWordT modelLoad(input opT op);
    int n;
    xlenWordT v;
    logic [7:0] b;
    n = 1 << op.req.size;
    v = '0;
    for (int k = 0; k < n; k++) begin
      b = modelMem.exists(longint'(op.adr + k)) ? modelMem[longint'(op.adr + k)] : 8'h00;
      if (op.req.bigEndian) v[8*(n-1-k) +: 8] = b;
      else v[8*k +: 8] = b;
    end
    if (!op.req.unsignedLoad && n < XlenBytes && v[8*n-1]) v = v | ('1 << (8*n)); // Sign fill
    return v;
  endfunction

  function automatic void modelStore(input opT op);
    int n;
    n = 1 << op.req.size;
    for (int k = 0; k < n; k++) begin
      if (op.req.bigEndian) modelMem[longint'(op.adr + k)] = op.wdata[8*(n-1-k) +: 8];
      else modelMem[longint'(op.adr + k)] = op.wdata[8*k +: 8];
    end
  endfunction

  //////////////////////////////////////////////////
  // Checks and bookkeeping
  //////////////////////////////////////////////////

  function automatic void tally(input int test, input bit ok);
    checks++;
    testChecks[test]++;
    if (!ok) begin
      errors++;
      testErrs[test]++;
    end
  endfunction

  task automatic checkReadData(input int test, input xlenWordT actual, input xlenWordT expected,
                               input string what);
    if (actual !== expected)
      $display("CHECK FAILED at %0t ns: test %0d %s, ReadDataW %h expected %h",
               $time, test, what, actual, expected);
    tally(test, actual === expected);
  endtask

  task automatic checkAddress(input int test, input xlenWordT actual, input xlenWordT expected);
    if (actual !== expected)
      $display("CHECK FAILED at %0t ns: test %0d IEUAdrM %h expected %h",
               $time, test, actual, expected);
    tally(test, actual === expected);
  endtask

  task automatic checkFaults(input int test, input faultPairT actual, input faultPairT expected);
    if (actual !== expected)
      $display("CHECK FAILED at %0t ns: test %0d faults load/store %b expected %b",
               $time, test, actual, expected);
    tally(test, actual === expected);
  endtask

  // Stimulus value that disagrees with the byte model
  function automatic void fileMismatch(input int test, input string what);
    $display("Stimulus file value for test %0d does not match the model: %s", test, what);
    tally(test, 1'b0);
  endfunction

  // One clock change at a time and bounded so a stuck clock is caught
  task automatic waitEdge(input logic level, input string what);
    int tries;
    tries = 0;
    do begin
      @(clk);
      tries++;
    end while (clk !== level && tries < EdgeTries);
    if (clk !== level) begin
      timedOut    = 1'b1;
      timeoutWhat = what;
    end
  endtask

  task automatic readStimulus();
    int fd, got, test, rw, size, uns, be, ctrl;
    xlenWordT adr, wdata, expRead;
    logic [1:0] fault;
    string line;
    opT op;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      $display("Cannot open %s", StimFile);
      fileError = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      got = $fgets(line, fd);
      if (line.len() < 2 || line.getc(0) == 8'h23) continue; // Blank or comment
      got = $sscanf(line, "%d %d %d %d %d %h %h %h %b %d",
                    test, rw, size, uns, be, adr, wdata, expRead, fault, ctrl);
      if (got != 10) begin
        $display("Malformed stimulus line: %s", line);
        fileError = 1'b1;
        continue;
      end
      op.test = test;
      op.req  = '{rw: memRwT'(rw), size: accessSizeT'(size), unsignedLoad: uns[0],
                  bigEndian: be[0]};
      op.adr = adr;
      op.wdata = wdata;
      op.expRead = expRead;
      op.expFault = fault;
      op.ctrl = ctrl[1:0];
      testChecks[test] = 0;
      testErrs[test] = 0;
      ops.push_back(op);
    end
    $fclose(fd);
  endtask

  // Faults and address are checked in M and the model advances in program order
  task automatic checkMStage(input int idx);
    opT op;
    faultPairT f;
    op = ops[idx];
    f = modelFault(op);
    if (f !== op.expFault) fileMismatch(op.test, "fault bits");
    checkAddress(op.test, IEUAdrM, op.adr);
    checkFaults(op.test, {LoadMisalignedFaultM, StoreAmoMisalignedFaultM}, f);
    readDue[idx] = op.req.rw == MemRead && !f.load;
    if (readDue[idx]) begin
      modelRead[idx] = modelLoad(op);
      if (modelRead[idx] !== op.expRead) fileMismatch(op.test, "read data");
    end
    if (op.req.rw == MemWrite && !f.store && op.ctrl != 2'd1) modelStore(op); // Flushed store dropped
  endtask

  // W keeps the last load result from the model while StallW is high
  task automatic holdUnderStall(input int test, input xlenWordT expected);
    for (int i = 0; i < HoldCycles && !timedOut; i++) begin
      waitEdge(1'b1, "clock rise under StallW");
      if (!timedOut) waitEdge(1'b0, "clock fall under StallW");
      if (!timedOut) checkReadData(test, ReadDataW, expected, "held under StallW");
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int n, mIdx;
    reset = 1'b1;
    StallM = 1'b0;
    FlushM = 1'b0;
    StallW = 1'b0;
    FlushW = 1'b0;
    IEUAdrE = '0;
    memReqM = '0;                                // Idle request
    WriteDataM = '0;
    checks = 0;
    errors = 0;
    readStimulus();
    n = ops.size();
    for (int i = 0; i < 10 && !timedOut; i++) waitEdge(1'b1, "reset cycles");
    reset <= 1'b0;
    for (int c = 0; c <= n + 1 && !timedOut && !fileError; c++) begin
      waitEdge(1'b1, "clock rise");
      if (timedOut) break;
      mIdx = c - 1;
      IEUAdrE <= (c < n) ? ops[c].adr : '0;      // Next op enters E
      if (mIdx >= 0 && mIdx < n) begin
        memReqM    <= ops[mIdx].req;             // Previous op now in M
        WriteDataM <= ops[mIdx].wdata;
        FlushW     <= ops[mIdx].ctrl == 2'd1;
        StallW     <= ops[mIdx].ctrl == 2'd2;
      end else begin
        memReqM    <= '0;
        WriteDataM <= '0;
        FlushW     <= 1'b0;
        StallW     <= 1'b0;
      end
      waitEdge(1'b0, "clock fall");
      if (timedOut) break;
      if (mIdx >= 0 && mIdx < n) checkMStage(mIdx);
      if (c >= 2 && readDue[c-2])
        checkReadData(ops[c-2].test, ReadDataW, modelRead[c-2], "load");
      if (mIdx >= 0 && mIdx < n && ops[mIdx].ctrl == 2'd2) begin
        if (c >= 2 && readDue[c-2]) holdUnderStall(ops[mIdx].test, modelRead[c-2]);
        else fileMismatch(ops[mIdx].test, "StallW hold without a preceding load");
      end
      if (c >= 2 && (c - 2 == n - 1 || ops[c-1].test != ops[c-2].test))
        $display("Test %0d done: %0d checks, %0d errors", ops[c-2].test,
                 testChecks[ops[c-2].test], testErrs[ops[c-2].test]);
    end
    if (timedOut) $display("Timed out waiting for %s", timeoutWhat);
    $display("Total checks %0d, errors %0d", checks, errors);
    if (!timedOut && !fileError && errors == 0 && checks > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- lsuTop.sv
// DTIM-only load/store datapath; no cache, bus, MMU or atomics behind it
`timescale 1ns/100ps

module lsuTop
  import lsuConfigPkg::*, lsuOpPkg::*;
#(
  parameter int DtimWords = 512                  // DTIM depth in words, power of two
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     StallM,                       // Hazard unit levels
  input  logic     FlushM,
  input  logic     StallW,
  input  logic     FlushW,
  input  xlenWordT IEUAdrE,                      // Address from E
  input  memReqT   memReqM,                      // Request in M
  input  xlenWordT WriteDataM,                   // Store data in M
  output xlenWordT IEUAdrM,
  output xlenWordT ReadDataW,                    // Load result in W
  output logic     LoadMisalignedFaultM,
  output logic     StoreAmoMisalignedFaultM
);

  localparam int DtimIndexBits = $clog2(DtimWords);

  logic [DtimIndexBits-1:0] dtimAdr;             // Word index into the array
  memRwT                    dtimRw;              // Gated direction
  xlenWordT                 dtimWriteData;       // Formatted store data
  byteMaskT                 byteMaskM;           // Store lanes
  xlenWordT                 dtimReadWord;        // Raw read word

  //////////////////////////////////////////////////
  // Address and store side
  //////////////////////////////////////////////////

  lsuAddressStage #(.DtimWords(DtimWords)) addressStage_i (
    .clk, .reset, .StallM, .FlushM, .FlushW, .IEUAdrE, .memReqM,
    .IEUAdrM, .dtimAdr, .dtimRw, .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM);

  lsuStoreFormat storeFormat_i (
    .memReqM, .IEUAdrM, .WriteDataM, .dtimWriteData, .byteMaskM);

  //////////////////////////////////////////////////
  // Memory and load side
  //////////////////////////////////////////////////

  dtimArray #(.DtimWords(DtimWords)) dtim_i (
    .clk, .enable(~StallW), .dtimRw, .dtimAdr, .dtimWriteData, .byteMaskM,
    .dtimReadWord);                              // StallW freezes the array with W

  lsuLoadFormat loadFormat_i (
    .clk, .reset, .StallW, .dtimReadWord, .memReqM, .IEUAdrM, .ReadDataW);

endmodule
